// File: Makefile
# Verilator build and run for the link sweep generator

VERILATOR ?= verilator
TOP       ?= tb_link_sweep
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when an RTL or testbench source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }
	@echo "Simulation passed, log in $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/level_sequencer.sv
`default_nettype none

module level_sequencer (
    input  wire                   wclk,
    input  wire                   rst,
    input  wire                   level_end,
    input  wire                   rx_parity,
    output link_test_pkg::level_t level,
    output logic                  run,
    output logic                  level_load,
    output logic                  sweep_clear,
    output logic                  sweep_next
);

    link_test_pkg::seq_state_t state;
    link_test_pkg::seq_state_t next_state;
    logic                      last_level;

    assign last_level = (level == link_test_pkg::LAST_LEVEL);

    always_ff @(posedge wclk or posedge rst) begin
        if (rst) begin
            state <= link_test_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            link_test_pkg::IDLE: begin
                next_state = link_test_pkg::WAIT;
            end
            link_test_pkg::WAIT: begin
                next_state = link_test_pkg::LOAD;
            end
            link_test_pkg::LOAD: begin
                next_state = link_test_pkg::RUN;
            end
            link_test_pkg::RUN: begin
                // Stay here until the generator has sent nibble 15 of this level
                if (level_end) begin
                    if (last_level) begin
                        next_state = link_test_pkg::DONE;
                    end else begin
                        next_state = link_test_pkg::LOAD;
                    end
                end
            end
            link_test_pkg::DONE: begin
                next_state = link_test_pkg::WAIT;
            end
            default: begin
                next_state = link_test_pkg::IDLE;
            end
        endcase
    end

    // Level stays put through LOAD and RUN and steps once per finished level
    always_ff @(posedge wclk or posedge rst) begin
        if (rst) begin
            level <= '0;
        end else if (state == link_test_pkg::IDLE || state == link_test_pkg::DONE) begin
            level <= '0;
        end else if (state == link_test_pkg::RUN && level_end && !last_level) begin
            level <= level + link_test_pkg::level_t'(1);
        end
    end

    assign run        = (state == link_test_pkg::RUN);
    assign level_load = (state == link_test_pkg::LOAD);

    // Odd parity of the last receive word restarts the sweep count, even parity advances it
    assign sweep_clear = (state == link_test_pkg::DONE) && rx_parity;
    assign sweep_next  = (state == link_test_pkg::DONE) && !rx_parity;

endmodule

`default_nettype wire

// File: source/link_sweep_top.sv
`default_nettype none

module link_sweep_top (
    input  wire                     wclk,
    input  wire                     rst,
    output logic                    tx_valid,
    input  wire                     tx_ready,
    output link_test_pkg::tx_beat_t tx_beat,
    input  wire                     rx_valid,
    output logic                    rx_ready,
    input  link_test_pkg::rx_word_t rx_word
);

    link_test_pkg::level_t level;
    logic                  run;
    logic                  level_load;
    logic                  sweep_clear;
    logic                  sweep_next;
    logic                  tick;
    logic                  level_end;
    logic                  rx_parity;

    level_sequencer u_level_sequencer (
        .wclk        (wclk),
        .rst         (rst),
        .level_end   (level_end),
        .rx_parity   (rx_parity),
        .level       (level),
        .run         (run),
        .level_load  (level_load),
        .sweep_clear (sweep_clear),
        .sweep_next  (sweep_next)
    );

    // The pending beat holds the timer until it has been taken
    step_timer u_step_timer (
        .wclk       (wclk),
        .rst        (rst),
        .run        (run),
        .level_load (level_load),
        .hold       (tx_valid),
        .level      (level),
        .tick       (tick)
    );

    nibble_pattern_gen u_nibble_pattern_gen (
        .wclk        (wclk),
        .rst         (rst),
        .tick        (tick),
        .level       (level),
        .sweep_clear (sweep_clear),
        .sweep_next  (sweep_next),
        .tx_ready    (tx_ready),
        .tx_valid    (tx_valid),
        .tx_beat     (tx_beat),
        .level_end   (level_end)
    );

    rx_parity_monitor u_rx_parity_monitor (
        .wclk      (wclk),
        .rst       (rst),
        .rx_valid  (rx_valid),
        .rx_word   (rx_word),
        .rx_ready  (rx_ready),
        .rx_parity (rx_parity)
    );

endmodule

`default_nettype wire

// File: source/link_test_pkg.sv
`default_nettype none

package link_test_pkg;

    localparam int LEVEL_W  = 4;
    localparam int NIBBLE_W = 4;
    localparam int SWEEP_W  = 4;

    typedef logic [LEVEL_W-1:0]  level_t;
    typedef logic [NIBBLE_W-1:0] nibble_t;
    typedef logic [SWEEP_W-1:0]  sweep_t;

    // The timer only ever counts up to the level, so it shares that width
    typedef logic [LEVEL_W-1:0]  tick_cnt_t;

    typedef struct packed {
        sweep_t  sweep;
        level_t  level;
        nibble_t nibble;
    } tx_beat_t;

    typedef struct packed {
        nibble_t data;
        logic    aux;
        logic    recv_a;
        logic    recv_b;
    } rx_word_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        LOAD,
        RUN,
        DONE
    } seq_state_t;

    localparam level_t  LAST_LEVEL  = level_t'(15);
    localparam nibble_t LAST_NIBBLE = nibble_t'(15);

endpackage

`default_nettype wire

// File: source/nibble_pattern_gen.sv
`default_nettype none

module nibble_pattern_gen (
    input  wire                     wclk,
    input  wire                     rst,
    input  wire                     tick,
    input  link_test_pkg::level_t   level,
    input  wire                     sweep_clear,
    input  wire                     sweep_next,
    input  wire                     tx_ready,
    output logic                    tx_valid,
    output link_test_pkg::tx_beat_t tx_beat,
    output logic                    level_end
);

    link_test_pkg::nibble_t nibble;
    link_test_pkg::sweep_t  sweep;
    logic                   tx_fire;

    assign tx_fire   = tx_valid && tx_ready;
    assign level_end = tx_fire && (tx_beat.nibble == link_test_pkg::LAST_NIBBLE);

    // Tick only comes while tx_valid is low, so it never meets a transfer
    always_ff @(posedge wclk or posedge rst) begin
        if (rst) begin
            tx_valid <= 1'b0;
        end else if (tick) begin
            tx_valid <= 1'b1;
        end else if (tx_fire) begin
            tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge wclk) begin
        if (tick) begin
            tx_beat.sweep  <= sweep;
            tx_beat.level  <= level;
            tx_beat.nibble <= nibble;
        end
    end

    always_ff @(posedge wclk or posedge rst) begin
        if (rst) begin
            nibble <= '0;
        end else if (tx_fire) begin
            if (nibble == link_test_pkg::LAST_NIBBLE) begin
                nibble <= '0;
            end else begin
                nibble <= nibble + link_test_pkg::nibble_t'(1);
            end
        end
    end

    // Sweep number changes only on the edge leaving DONE
    always_ff @(posedge wclk or posedge rst) begin
        if (rst) begin
            sweep <= '0;
        end else if (sweep_clear) begin
            sweep <= '0;
        end else if (sweep_next) begin
            sweep <= sweep + link_test_pkg::sweep_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: source/rx_parity_monitor.sv
`default_nettype none

module rx_parity_monitor (
    input  wire                     wclk,
    input  wire                     rst,
    input  wire                     rx_valid,
    input  link_test_pkg::rx_word_t rx_word,
    output logic                    rx_ready,
    output logic                    rx_parity
);

    logic rx_fire;
    logic word_parity;

    // The monitor never stalls the receive side once out of reset
    assign rx_ready = !rst;

    assign rx_fire = rx_valid && rx_ready;

    // All seven bits count, including the status flags next to the data nibble
    assign word_parity = ^rx_word;

    always_ff @(posedge wclk or posedge rst) begin
        if (rst) begin
            rx_parity <= 1'b0;
        end else if (rx_fire) begin
            rx_parity <= word_parity;
        end
    end

endmodule

`default_nettype wire

// File: source/step_timer.sv
`default_nettype none

module step_timer (
    input  wire                   wclk,
    input  wire                   rst,
    input  wire                   run,
    input  wire                   level_load,
    input  wire                   hold,
    input  link_test_pkg::level_t level,
    output logic                  tick
);

    link_test_pkg::tick_cnt_t cnt;
    logic                     counting;

    // A pending beat freezes the count so back-pressure never shortens an interval
    assign counting = run && !hold;

    // Level L gives L+1 counting cycles plus the cycle the beat is on the bus
    assign tick = counting && (cnt == level);

    always_ff @(posedge wclk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (level_load) begin
            cnt <= '0;
        end else if (counting) begin
            if (tick) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + link_test_pkg::tick_cnt_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: src.f
source/link_test_pkg.sv
source/level_sequencer.sv
source/step_timer.sv
source/nibble_pattern_gen.sv
source/rx_parity_monitor.sv
source/link_sweep_top.sv
tb/tb_link_sweep.sv

// File: tb/link_sweep_input.txt
# rx_word (hex, 7 bits) sent once per sweep, tx_ready percentage (decimal)
# One line per sweep, the word's parity sets the next sweep number
03 100
05 70
07 50
00 100
7f 40
11 85
33 60
55 90
6a 35
01 100
18 75
2c 55
46 80
0f 45
3c 95
5a 65
21 100
70 50

// File: tb/tb_link_sweep.sv
`default_nettype none

module tb_link_sweep;

    localparam int BEAT_TIMEOUT = 400;

    logic                    wclk;
    logic                    rst;
    logic                    tx_valid;
    logic                    tx_ready;
    link_test_pkg::tx_beat_t tx_beat;
    logic                    rx_valid;
    logic                    rx_ready;
    link_test_pkg::rx_word_t rx_word;

    link_test_pkg::rx_word_t word_q[$];
    int unsigned             pct_q[$];

    logic [31:0]             lcg_state;
    int                      cycle_count;
    int unsigned             ready_pct;
    logic                    send_rx;
    link_test_pkg::rx_word_t sweep_word;

    // What the bus showed in the previous cycle, to check that a stalled beat holds
    logic                    prev_valid;
    logic                    prev_ready;
    link_test_pkg::tx_beat_t prev_beat;

    link_sweep_top u_dut (
        .wclk     (wclk),
        .rst      (rst),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_beat  (tx_beat),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .rx_word  (rx_word)
    );

    initial wclk = 1'b0;
    always #2 wclk = ~wclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "%s", msg);
    endtask

    task automatic compare_beat(input string name, input link_test_pkg::tx_beat_t got,
                                input link_test_pkg::tx_beat_t exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH time=%0t %s got=%h expected=%h",
                               $time, name, got, exp));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH time=%0t %s got=%b expected=%b",
                               $time, name, got, exp));
        end
    endtask

    task automatic compare_gap(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_now($sformatf("MISMATCH time=%0t %s got=%0d expected=%0d",
                               $time, name, got, exp));
        end
    endtask

    // Runs one clock cycle with the hold check, drives the inputs and reports a transfer
    task automatic run_cycle(output logic fired);
        @(posedge wclk);
        #1;
        cycle_count++;
        if (prev_valid && !prev_ready) begin
            compare_bit("tx_valid", tx_valid, 1'b1);
            compare_beat("tx_beat", tx_beat, prev_beat);
        end
        lcg_state = lcg_next(lcg_state);
        tx_ready  = (((lcg_state >> 16) % 32'd100) < ready_pct);
        if (send_rx) begin
            rx_valid = 1'b1;
            rx_word  = sweep_word;
            compare_bit("rx_ready", rx_ready, 1'b1);
            send_rx  = 1'b0;
        end else begin
            rx_valid = 1'b0;
        end
        fired      = tx_valid && tx_ready;
        prev_valid = tx_valid;
        prev_ready = tx_ready;
        prev_beat  = tx_beat;
    endtask

    initial begin
        int                      fd;
        int                      n;
        string                   line;
        logic [31:0]             word_tmp;
        int unsigned             pct_tmp;
        logic                    fired;
        int                      waited;
        int                      last_fire;
        link_test_pkg::sweep_t   exp_sweep;
        link_test_pkg::tx_beat_t exp_beat;

        rst         = 1'b1;
        tx_ready    = 1'b0;
        rx_valid    = 1'b0;
        rx_word     = '0;
        lcg_state   = 32'hf2a5_503b;
        cycle_count = 0;
        ready_pct   = 0;
        send_rx     = 1'b0;
        sweep_word  = '0;
        prev_valid  = 1'b0;
        prev_ready  = 1'b0;
        prev_beat   = '0;
        last_fire   = 0;
        exp_sweep   = '0;

        fd = $fopen("tb/link_sweep_input.txt", "r");
        if (fd == 0) begin
            fail_now("cannot open the stimulus file tb/link_sweep_input.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.substr(0, 0) != "#") begin
                if ($sscanf(line, "%h %d", word_tmp, pct_tmp) == 2) begin
                    word_q.push_back(link_test_pkg::rx_word_t'(word_tmp[6:0]));
                    pct_q.push_back(pct_tmp);
                end
            end
        end
        $fclose(fd);
        if (word_q.size() == 0) begin
            fail_now("the stimulus file holds no sweep lines");
        end

        @(posedge wclk);
        #1;
        compare_bit("tx_valid", tx_valid, 1'b0);
        compare_bit("rx_ready", rx_ready, 1'b0);
        @(posedge wclk);
        #1;
        rst = 1'b0;
        @(posedge wclk);
        #1;
        compare_bit("rx_ready", rx_ready, 1'b1);

        for (int s = 0; s < word_q.size(); s++) begin
            ready_pct  = pct_q[s];
            sweep_word = word_q[s];
            for (int lvl = 0; lvl < 16; lvl++) begin
                for (int nib = 0; nib < 16; nib++) begin
                    // The receive word goes out once, early in the sweep
                    if (lvl == 2 && nib == 0) begin
                        send_rx = 1'b1;
                    end
                    fired  = 1'b0;
                    waited = 0;
                    while (!fired && waited < BEAT_TIMEOUT) begin
                        run_cycle(fired);
                        waited++;
                    end
                    if (!fired) begin
                        fail_now($sformatf("no beat within %0d cycles in sweep %0d",
                                           BEAT_TIMEOUT, s));
                    end else begin
                        exp_beat.sweep  = exp_sweep;
                        exp_beat.level  = link_test_pkg::level_t'(lvl);
                        exp_beat.nibble = link_test_pkg::nibble_t'(nib);
                        compare_beat("tx_beat", tx_beat, exp_beat);
                        if (ready_pct == 100 && nib > 0) begin
                            compare_gap("beat gap", cycle_count - last_fire, lvl + 2);
                        end
                        last_fire = cycle_count;
                    end
                end
            end
            // Odd parity of this sweep's word restarts the count
            if (^sweep_word) begin
                exp_sweep = '0;
            end else begin
                exp_sweep = exp_sweep + link_test_pkg::sweep_t'(1);
            end
        end

        // One more beat must open a new sweep with the number set by the last word
        fired  = 1'b0;
        waited = 0;
        while (!fired && waited < BEAT_TIMEOUT) begin
            run_cycle(fired);
            waited++;
        end
        if (!fired) begin
            fail_now($sformatf("no beat within %0d cycles after the last sweep",
                               BEAT_TIMEOUT));
        end else begin
            exp_beat.sweep  = exp_sweep;
            exp_beat.level  = '0;
            exp_beat.nibble = '0;
            compare_beat("tx_beat", tx_beat, exp_beat);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
